// ==== logic/mon_consts.svh ====
// Shared constants for the AXI transaction monitor
// Include in any file that needs bus widths, FIFO sizing or agent numbers

`ifndef MON_CONSTS_SVH
`define MON_CONSTS_SVH

// AXI field widths
`define AXI_ID_WIDTH     4
`define AXI_ADDR_WIDTH   32

// Packet buffering and aggregation
`define MON_FIFO_DEPTH   4
`define MON_NUM_SOURCES  4

// Unit number carried in every packet
`define MON_UNIT_ID      1

// Agent numbers, one per monitor
`define AGENT_M0_RD      8'h10
`define AGENT_M0_WR      8'h11
`define AGENT_M1_RD      8'h12
`define AGENT_M1_WR      8'h13

`endif

// ==== logic/axi_fields_pkg.sv ====
// AXI field types seen by the read and write monitors
// Import with axi_fields_pkg::* where ID, address or response values are handled

`include "mon_consts.svh"

package axi_fields_pkg;

    typedef logic [`AXI_ID_WIDTH-1:0]   axi_id_t;
    typedef logic [`AXI_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [1:0]                 axi_resp_t;

    // Response codes, ordered from best to worst
    localparam axi_resp_t AXI_RESP_OKAY   = 2'd0;
    localparam axi_resp_t AXI_RESP_EXOKAY = 2'd1;
    localparam axi_resp_t AXI_RESP_SLVERR = 2'd2;
    localparam axi_resp_t AXI_RESP_DECERR = 2'd3;

endpackage

// ==== logic/monbus_pkg.sv ====
// Monitor bus packet format
// Import with monbus_pkg::* in anything that builds, buffers or routes packets

package monbus_pkg;

    typedef logic [63:0] monbus_pkt_t;
    typedef logic [7:0]  agent_id_t;
    typedef logic [3:0]  unit_id_t;

    typedef enum logic [3:0] {
        PKT_COMPL = 4'd1,
        PKT_ERROR = 4'd2
    } pkt_type_e;

    // Packet layout, top bit down
    //   63:60 type, 59:56 unit, 55:48 agent, 47:44 AXI ID
    //   43:42 response, 41:32 zero, 31:0 start address
    function automatic monbus_pkt_t make_pkt(
        input pkt_type_e   pkt_type,
        input unit_id_t    unit_id,
        input agent_id_t   agent_id,
        input logic [3:0]  axi_id,
        input logic [1:0]  resp,
        input logic [31:0] addr
    );
        return {pkt_type, unit_id, agent_id, axi_id, resp, 10'd0, addr};
    endfunction

endpackage

// ==== logic/monbus_pkt_fifo.sv ====
// Per-source packet buffer
// Holds completed packets until the round-robin arbiter gets to this source

`timescale 1ns/1ps

`include "mon_consts.svh"

module monbus_pkt_fifo import monbus_pkg::*; (
    input  logic        aclk,
    input  logic        rst,
    input  logic        push,
    input  monbus_pkt_t push_pkt,
    input  logic        pop,
    output monbus_pkt_t head_pkt,
    output logic        not_empty,
    output logic        full
);

    localparam int DEPTH = `MON_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;

    monbus_pkt_t       mem [DEPTH];
    ptr_t              wr_ptr;
    ptr_t              rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    assign full      = (count == CNT_W'(DEPTH));
    assign not_empty = (count != '0);
    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;
    assign head_pkt  = mem[rd_ptr];

    // Storage
    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_pkt;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge aclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== logic/axi_rd_txn_mon.sv ====
// Read-path monitor for one AXI master
// Records each AR burst by ID and emits one packet at its last R beat

`timescale 1ns/1ps

`include "mon_consts.svh"

module axi_rd_txn_mon import axi_fields_pkg::*, monbus_pkg::*; #(
    parameter agent_id_t AGENT_ID = `AGENT_M0_RD
) (
    input  logic        aclk,
    input  logic        rst,
    input  axi_id_t     arid,
    input  axi_addr_t   araddr,
    input  logic        arvalid,
    input  logic        arready,
    input  axi_id_t     rid,
    input  axi_resp_t   rresp,
    input  logic        rlast,
    input  logic        rvalid,
    input  logic        rready,
    input  logic        cfg_error_enable,
    input  logic        cfg_compl_enable,
    output monbus_pkt_t src_pkt,
    output logic        src_not_empty,
    input  logic        src_pop
);

    localparam int NUM_IDS = 2 ** `AXI_ID_WIDTH;

    // ========================================
    // Outstanding burst table
    // ========================================
    axi_addr_t          tbl_addr  [NUM_IDS];
    axi_resp_t          tbl_worst [NUM_IDS];
    logic [NUM_IDS-1:0] tbl_err;
    logic [NUM_IDS-1:0] tbl_valid;

    logic        ar_hs;
    logic        r_hs;
    logic        beat_err;
    logic        burst_err;
    axi_resp_t   burst_worst;
    logic        push;
    monbus_pkt_t push_pkt;

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    // Fold the current beat into what the table already holds
    assign beat_err    = (rresp == AXI_RESP_SLVERR) || (rresp == AXI_RESP_DECERR);
    assign burst_err   = tbl_err[rid] || beat_err;
    assign burst_worst = (rresp > tbl_worst[rid]) ? rresp : tbl_worst[rid];

    always_ff @(posedge aclk) begin
        if (ar_hs) begin
            tbl_addr[arid] <= araddr;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            tbl_valid <= '0;
            tbl_err   <= '0;
            tbl_worst <= '{default: AXI_RESP_OKAY};
        end else begin
            if (r_hs) begin
                tbl_err[rid]   <= burst_err;
                tbl_worst[rid] <= burst_worst;
                if (rlast) begin
                    tbl_valid[rid] <= 1'b0;
                end
            end
            // A new burst on an ID starts clean
            if (ar_hs) begin
                tbl_valid[arid] <= 1'b1;
                tbl_err[arid]   <= 1'b0;
                tbl_worst[arid] <= AXI_RESP_OKAY;
            end
        end
    end

    // ========================================
    // Packet generation
    // ========================================
    assign push = r_hs && rlast && tbl_valid[rid]
               && (burst_err ? cfg_error_enable : cfg_compl_enable);

    assign push_pkt = make_pkt(burst_err ? PKT_ERROR : PKT_COMPL, unit_id_t'(`MON_UNIT_ID),
                               AGENT_ID, rid, burst_worst, tbl_addr[rid]);

    monbus_pkt_fifo u_pkt_fifo (
        .aclk      (aclk),
        .rst       (rst),
        .push      (push),
        .push_pkt  (push_pkt),
        .pop       (src_pop),
        .head_pkt  (src_pkt),
        .not_empty (src_not_empty),
        .full      ()
    );

endmodule

// ==== logic/axi_wr_txn_mon.sv ====
// Write-path monitor for one AXI master
// Records each AW burst by ID and emits one packet at its B handshake

`timescale 1ns/1ps

`include "mon_consts.svh"

module axi_wr_txn_mon import axi_fields_pkg::*, monbus_pkg::*; #(
    parameter agent_id_t AGENT_ID = `AGENT_M0_WR
) (
    input  logic        aclk,
    input  logic        rst,
    input  axi_id_t     awid,
    input  axi_addr_t   awaddr,
    input  logic        awvalid,
    input  logic        awready,
    input  axi_id_t     bid,
    input  axi_resp_t   bresp,
    input  logic        bvalid,
    input  logic        bready,
    input  logic        cfg_error_enable,
    input  logic        cfg_compl_enable,
    output monbus_pkt_t src_pkt,
    output logic        src_not_empty,
    input  logic        src_pop
);

    localparam int NUM_IDS = 2 ** `AXI_ID_WIDTH;

    axi_addr_t          tbl_addr [NUM_IDS];
    logic [NUM_IDS-1:0] tbl_valid;

    logic        aw_hs;
    logic        b_hs;
    logic        b_err;
    logic        push;
    monbus_pkt_t push_pkt;

    assign aw_hs = awvalid && awready;
    assign b_hs  = bvalid && bready;
    assign b_err = (bresp == AXI_RESP_SLVERR) || (bresp == AXI_RESP_DECERR);

    // Start address per ID
    always_ff @(posedge aclk) begin
        if (aw_hs) begin
            tbl_addr[awid] <= awaddr;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            tbl_valid <= '0;
        end else begin
            if (b_hs) begin
                tbl_valid[bid] <= 1'b0;
            end
            if (aw_hs) begin
                tbl_valid[awid] <= 1'b1;
            end
        end
    end

    // Responses for IDs with no recorded AW are ignored
    assign push = b_hs && tbl_valid[bid] && (b_err ? cfg_error_enable : cfg_compl_enable);

    assign push_pkt = make_pkt(b_err ? PKT_ERROR : PKT_COMPL, unit_id_t'(`MON_UNIT_ID),
                               AGENT_ID, bid, bresp, tbl_addr[bid]);

    monbus_pkt_fifo u_pkt_fifo (
        .aclk      (aclk),
        .rst       (rst),
        .push      (push),
        .push_pkt  (push_pkt),
        .pop       (src_pop),
        .head_pkt  (src_pkt),
        .not_empty (src_not_empty),
        .full      ()
    );

endmodule

// ==== logic/monbus_rr_arbiter.sv ====
// Round-robin merge of the packet sources onto the monitor bus
// Pops one packet per cycle and presents it as a one-cycle strobe the next cycle

`timescale 1ns/1ps

`include "mon_consts.svh"

module monbus_rr_arbiter import monbus_pkg::*; (
    input  logic                        aclk,
    input  logic                        rst,
    input  logic [`MON_NUM_SOURCES-1:0] src_not_empty,
    input  monbus_pkt_t                 src_pkt [`MON_NUM_SOURCES],
    output logic [`MON_NUM_SOURCES-1:0] src_pop,
    output logic                        monbus_valid,
    output monbus_pkt_t                 monbus_data
);

    localparam int N     = `MON_NUM_SOURCES;
    localparam int IDX_W = $clog2(N);

    typedef logic [IDX_W-1:0] src_idx_t;

    // Highest-priority source for the next search
    src_idx_t rr_ptr;
    src_idx_t grant_idx;
    logic     grant_found;

    // ========================================
    // Grant search starting at rr_ptr
    // ========================================
    always_comb begin
        int idx;
        grant_found = 1'b0;
        grant_idx   = '0;
        for (int i = 0; i < N; i++) begin
            idx = (int'(rr_ptr) + i) % N;
            if (!grant_found && src_not_empty[idx]) begin
                grant_found = 1'b1;
                grant_idx   = src_idx_t'(idx);
            end
        end
    end

    always_comb begin
        src_pop            = '0;
        src_pop[grant_idx] = grant_found;
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            rr_ptr       <= '0;
            monbus_valid <= 1'b0;
        end else begin
            monbus_valid <= grant_found;
            if (grant_found) begin
                rr_ptr <= (grant_idx == src_idx_t'(N - 1)) ? '0 : grant_idx + 1'b1;
            end
        end
    end

    // Output data register
    always_ff @(posedge aclk) begin
        if (grant_found) begin
            monbus_data <= src_pkt[grant_idx];
        end
    end

endmodule

// ==== logic/axi_monitor_top.sv ====
// Passive AXI monitor for two bus masters
// Every AXI signal is observed only; packets leave on monbus_valid and monbus_data

`timescale 1ns/1ps

`include "mon_consts.svh"

module axi_monitor_top import monbus_pkg::*; (
    input  logic                       aclk,
    input  logic                       rst,

    // Master 0
    input  logic [`AXI_ID_WIDTH-1:0]   m0_arid,
    input  logic [`AXI_ADDR_WIDTH-1:0] m0_araddr,
    input  logic                       m0_arvalid,
    input  logic                       m0_arready,
    input  logic [`AXI_ID_WIDTH-1:0]   m0_rid,
    input  logic [1:0]                 m0_rresp,
    input  logic                       m0_rlast,
    input  logic                       m0_rvalid,
    input  logic                       m0_rready,
    input  logic [`AXI_ID_WIDTH-1:0]   m0_awid,
    input  logic [`AXI_ADDR_WIDTH-1:0] m0_awaddr,
    input  logic                       m0_awvalid,
    input  logic                       m0_awready,
    input  logic [`AXI_ID_WIDTH-1:0]   m0_bid,
    input  logic [1:0]                 m0_bresp,
    input  logic                       m0_bvalid,
    input  logic                       m0_bready,

    // Master 1
    input  logic [`AXI_ID_WIDTH-1:0]   m1_arid,
    input  logic [`AXI_ADDR_WIDTH-1:0] m1_araddr,
    input  logic                       m1_arvalid,
    input  logic                       m1_arready,
    input  logic [`AXI_ID_WIDTH-1:0]   m1_rid,
    input  logic [1:0]                 m1_rresp,
    input  logic                       m1_rlast,
    input  logic                       m1_rvalid,
    input  logic                       m1_rready,
    input  logic [`AXI_ID_WIDTH-1:0]   m1_awid,
    input  logic [`AXI_ADDR_WIDTH-1:0] m1_awaddr,
    input  logic                       m1_awvalid,
    input  logic                       m1_awready,
    input  logic [`AXI_ID_WIDTH-1:0]   m1_bid,
    input  logic [1:0]                 m1_bresp,
    input  logic                       m1_bvalid,
    input  logic                       m1_bready,

    input  logic                       cfg_error_enable,
    input  logic                       cfg_compl_enable,
    output logic                       monbus_valid,
    output monbus_pkt_t                monbus_data
);

    // Source order is M0 read, M0 write, M1 read, M1 write
    logic [`MON_NUM_SOURCES-1:0] src_not_empty;
    logic [`MON_NUM_SOURCES-1:0] src_pop;
    monbus_pkt_t                 src_pkt [`MON_NUM_SOURCES];

    // ========================================
    // Master 0 monitors
    // ========================================
    axi_rd_txn_mon #(.AGENT_ID(`AGENT_M0_RD)) u_m0_rd_mon (
        .aclk             (aclk),
        .rst              (rst),
        .arid             (m0_arid),
        .araddr           (m0_araddr),
        .arvalid          (m0_arvalid),
        .arready          (m0_arready),
        .rid              (m0_rid),
        .rresp            (m0_rresp),
        .rlast            (m0_rlast),
        .rvalid           (m0_rvalid),
        .rready           (m0_rready),
        .cfg_error_enable (cfg_error_enable),
        .cfg_compl_enable (cfg_compl_enable),
        .src_pkt          (src_pkt[0]),
        .src_not_empty    (src_not_empty[0]),
        .src_pop          (src_pop[0])
    );

    axi_wr_txn_mon #(.AGENT_ID(`AGENT_M0_WR)) u_m0_wr_mon (
        .aclk             (aclk),
        .rst              (rst),
        .awid             (m0_awid),
        .awaddr           (m0_awaddr),
        .awvalid          (m0_awvalid),
        .awready          (m0_awready),
        .bid              (m0_bid),
        .bresp            (m0_bresp),
        .bvalid           (m0_bvalid),
        .bready           (m0_bready),
        .cfg_error_enable (cfg_error_enable),
        .cfg_compl_enable (cfg_compl_enable),
        .src_pkt          (src_pkt[1]),
        .src_not_empty    (src_not_empty[1]),
        .src_pop          (src_pop[1])
    );

    // ========================================
    // Master 1 monitors
    // ========================================
    axi_rd_txn_mon #(.AGENT_ID(`AGENT_M1_RD)) u_m1_rd_mon (
        .aclk             (aclk),
        .rst              (rst),
        .arid             (m1_arid),
        .araddr           (m1_araddr),
        .arvalid          (m1_arvalid),
        .arready          (m1_arready),
        .rid              (m1_rid),
        .rresp            (m1_rresp),
        .rlast            (m1_rlast),
        .rvalid           (m1_rvalid),
        .rready           (m1_rready),
        .cfg_error_enable (cfg_error_enable),
        .cfg_compl_enable (cfg_compl_enable),
        .src_pkt          (src_pkt[2]),
        .src_not_empty    (src_not_empty[2]),
        .src_pop          (src_pop[2])
    );

    axi_wr_txn_mon #(.AGENT_ID(`AGENT_M1_WR)) u_m1_wr_mon (
        .aclk             (aclk),
        .rst              (rst),
        .awid             (m1_awid),
        .awaddr           (m1_awaddr),
        .awvalid          (m1_awvalid),
        .awready          (m1_awready),
        .bid              (m1_bid),
        .bresp            (m1_bresp),
        .bvalid           (m1_bvalid),
        .bready           (m1_bready),
        .cfg_error_enable (cfg_error_enable),
        .cfg_compl_enable (cfg_compl_enable),
        .src_pkt          (src_pkt[3]),
        .src_not_empty    (src_not_empty[3]),
        .src_pop          (src_pop[3])
    );

    monbus_rr_arbiter u_arbiter (
        .aclk          (aclk),
        .rst           (rst),
        .src_not_empty (src_not_empty),
        .src_pkt       (src_pkt),
        .src_pop       (src_pop),
        .monbus_valid  (monbus_valid),
        .monbus_data   (monbus_data)
    );

endmodule

// ==== sim/axi_monitor_props.sv ====
// FIFO protocol assertions for the monitor packet buffers
// Bound into every monbus_pkt_fifo; fail_count is read by the testbench at the end

`timescale 1ns/1ps

module axi_monitor_props (
    input logic aclk,
    input logic rst,
    input logic push,
    input logic pop,
    input logic full,
    input logic not_empty
);

    int fail_count = 0;

    // Completions must be spaced so no packet is dropped
    push_not_full: assert property (@(posedge aclk) disable iff (rst) push |-> !full)
        else begin
            fail_count++;
            $error("packet pushed into a full FIFO");
        end

    pop_not_empty: assert property (@(posedge aclk) disable iff (rst) pop |-> not_empty)
        else begin
            fail_count++;
            $error("pop from an empty FIFO");
        end

endmodule

bind monbus_pkt_fifo axi_monitor_props u_props (
    .aclk      (aclk),
    .rst       (rst),
    .push      (push),
    .pop       (pop),
    .full      (full),
    .not_empty (not_empty)
);

// ==== sim/axi_monitor_tb.sv ====
// Testbench for the two-master AXI transaction monitor
// Random AXI traffic on all four paths, checked against a model with per-agent queues

`timescale 1ns/1ps

`include "mon_consts.svh"

module axi_monitor_tb import axi_fields_pkg::*, monbus_pkg::*; ();

    localparam int NUM_PHASES  = 6;
    localparam int PAIRS       = 5;
    // Reset, idle check, worst-case pair length per phase, drain margin
    localparam int CYCLE_LIMIT = 16 + 8 + NUM_PHASES * PAIRS * 40 + 200;

    logic        aclk = 1'b0;
    logic        rst;
    logic        cfg_error_enable;
    logic        cfg_compl_enable;
    logic        monbus_valid;
    monbus_pkt_t monbus_data;

    // AXI signals, indexed by master
    axi_id_t   arid [2];
    axi_addr_t araddr [2];
    logic      arvalid [2];
    logic      arready [2];
    axi_id_t   rid [2];
    axi_resp_t rresp [2];
    logic      rlast [2];
    logic      rvalid [2];
    logic      rready [2];
    axi_id_t   awid [2];
    axi_addr_t awaddr [2];
    logic      awvalid [2];
    logic      awready [2];
    axi_id_t   bid [2];
    axi_resp_t bresp [2];
    logic      bvalid [2];
    logic      bready [2];

    // Model state, indexed by source 0..3
    axi_addr_t   out_addr [4][16];
    monbus_pkt_t exp_q [4][$];

    integer      seed;
    integer      seeds [4];
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycle_count = 0;
    monbus_pkt_t mon_exp;
    int          mon_src;

    always #4 aclk = ~aclk;

    axi_monitor_top axi_monitor_top_i (
        .aclk (aclk), .rst (rst),
        .m0_arid (arid[0]), .m0_araddr (araddr[0]), .m0_arvalid (arvalid[0]),
        .m0_arready (arready[0]), .m0_rid (rid[0]), .m0_rresp (rresp[0]),
        .m0_rlast (rlast[0]), .m0_rvalid (rvalid[0]), .m0_rready (rready[0]),
        .m0_awid (awid[0]), .m0_awaddr (awaddr[0]), .m0_awvalid (awvalid[0]),
        .m0_awready (awready[0]), .m0_bid (bid[0]), .m0_bresp (bresp[0]),
        .m0_bvalid (bvalid[0]), .m0_bready (bready[0]),
        .m1_arid (arid[1]), .m1_araddr (araddr[1]), .m1_arvalid (arvalid[1]),
        .m1_arready (arready[1]), .m1_rid (rid[1]), .m1_rresp (rresp[1]),
        .m1_rlast (rlast[1]), .m1_rvalid (rvalid[1]), .m1_rready (rready[1]),
        .m1_awid (awid[1]), .m1_awaddr (awaddr[1]), .m1_awvalid (awvalid[1]),
        .m1_awready (awready[1]), .m1_bid (bid[1]), .m1_bresp (bresp[1]),
        .m1_bvalid (bvalid[1]), .m1_bready (bready[1]),
        .cfg_error_enable (cfg_error_enable), .cfg_compl_enable (cfg_compl_enable),
        .monbus_valid (monbus_valid), .monbus_data (monbus_data)
    );

    // ========================================
    // Model helpers
    // ========================================
    function automatic agent_id_t agent_of(input int src);
        case (src)
            0:       return `AGENT_M0_RD;
            1:       return `AGENT_M0_WR;
            2:       return `AGENT_M1_RD;
            default: return `AGENT_M1_WR;
        endcase
    endfunction

    // Mostly good responses, one in four an error
    function automatic axi_resp_t resp_from(input int v);
        case (v)
            0:       return AXI_RESP_SLVERR;
            1:       return AXI_RESP_DECERR;
            2:       return AXI_RESP_EXOKAY;
            default: return AXI_RESP_OKAY;
        endcase
    endfunction

    function automatic monbus_pkt_t build_expected(input int src, input axi_id_t id,
                                                   input axi_resp_t resp);
        pkt_type_e t;
        t = (resp == AXI_RESP_SLVERR || resp == AXI_RESP_DECERR) ? PKT_ERROR : PKT_COMPL;
        return {t, unit_id_t'(`MON_UNIT_ID), agent_of(src), id, resp, 10'd0,
                out_addr[src][id]};
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int i = 0; i < 4; i++) begin
            n += exp_q[i].size();
        end
        return n;
    endfunction

    function automatic int assert_failures();
        return axi_monitor_top_i.u_m0_rd_mon.u_pkt_fifo.u_props.fail_count
             + axi_monitor_top_i.u_m0_wr_mon.u_pkt_fifo.u_props.fail_count
             + axi_monitor_top_i.u_m1_rd_mon.u_pkt_fifo.u_props.fail_count
             + axi_monitor_top_i.u_m1_wr_mon.u_pkt_fifo.u_props.fail_count;
    endfunction

    task automatic record_completion(input int src, input axi_id_t id, input axi_resp_t resp);
        logic err;
        err = (resp == AXI_RESP_SLVERR) || (resp == AXI_RESP_DECERR);
        if (err ? cfg_error_enable : cfg_compl_enable) begin
            exp_q[src].push_back(build_expected(src, id, resp));
        end
    endtask

    // ========================================
    // Compare tasks
    // ========================================
    task automatic compare_pkt(input string name, input monbus_pkt_t got,
                               input monbus_pkt_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_type(input string name, input pkt_type_e got, input pkt_type_e exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // ========================================
    // Stimulus
    // ========================================
    task automatic step_cycle();
        @(posedge aclk);
        #1;
    endtask

    task automatic run_read_path(input int m);
        int        src;
        int        len;
        axi_id_t   ids [2];
        axi_addr_t addr;
        axi_resp_t resp;
        axi_resp_t worst;
        src = 2 * m;
        repeat (PAIRS) begin
            ids[0] = axi_id_t'($random(seeds[src]));
            ids[1] = ids[0] + axi_id_t'(1 + {$random(seeds[src])} % 15);
            for (int k = 0; k < 2; k++) begin
                addr = $random(seeds[src]);
                out_addr[src][ids[k]] = addr;
                arid[m] = ids[k];
                araddr[m] = addr;
                arvalid[m] = 1'b1;
                step_cycle();
            end
            arvalid[m] = 1'b0;
            // Reverse order, so the table lookup by ID matters
            for (int k = 1; k >= 0; k--) begin
                len = 1 + {$random(seeds[src])} % 4;
                worst = AXI_RESP_OKAY;
                for (int b = 0; b < len; b++) begin
                    resp = resp_from({$random(seeds[src])} % 8);
                    if (resp > worst) begin
                        worst = resp;
                    end
                    rid[m] = ids[k];
                    rresp[m] = resp;
                    rlast[m] = (b == len - 1);
                    rvalid[m] = 1'b1;
                    rready[m] = 1'b0;
                    while ({$random(seeds[src])} % 4 == 0) begin
                        step_cycle();
                    end
                    rready[m] = 1'b1;
                    if (b == len - 1) begin
                        record_completion(src, ids[k], worst);
                    end
                    step_cycle();
                end
                rvalid[m] = 1'b0;
                rlast[m] = 1'b0;
                repeat (4 - len) step_cycle();
            end
        end
    endtask

    task automatic run_write_path(input int m);
        int        src;
        axi_id_t   ids [2];
        axi_addr_t addr;
        axi_resp_t resp;
        src = 2 * m + 1;
        repeat (PAIRS) begin
            ids[0] = axi_id_t'($random(seeds[src]));
            ids[1] = ids[0] + axi_id_t'(1 + {$random(seeds[src])} % 15);
            for (int k = 0; k < 2; k++) begin
                addr = $random(seeds[src]);
                out_addr[src][ids[k]] = addr;
                awid[m] = ids[k];
                awaddr[m] = addr;
                awvalid[m] = 1'b1;
                step_cycle();
            end
            awvalid[m] = 1'b0;
            for (int k = 1; k >= 0; k--) begin
                resp = resp_from({$random(seeds[src])} % 8);
                bid[m] = ids[k];
                bresp[m] = resp;
                bvalid[m] = 1'b1;
                bready[m] = 1'b0;
                while ({$random(seeds[src])} % 4 == 0) begin
                    step_cycle();
                end
                bready[m] = 1'b1;
                record_completion(src, ids[k], resp);
                step_cycle();
                bvalid[m] = 1'b0;
                repeat (3) step_cycle();
            end
        end
    endtask

    // ========================================
    // Monitor bus checker
    // ========================================
    always @(posedge aclk) begin
        if (!rst && monbus_valid === 1'b1) begin
            mon_src = -1;
            for (int i = 0; i < 4; i++) begin
                if (monbus_data[55:48] == agent_of(i)) begin
                    mon_src = i;
                end
            end
            if (mon_src < 0) begin
                other_errors++;
                $display("Packet with unknown agent %h at %0t", monbus_data[55:48], $time);
            end else if (exp_q[mon_src].size() == 0) begin
                other_errors++;
                $display("Unexpected packet %h from agent %0d at %0t", monbus_data,
                         mon_src, $time);
            end else begin
                mon_exp = exp_q[mon_src].pop_front();
                compare_type("monbus_data type", pkt_type_e'(monbus_data[63:60]),
                             pkt_type_e'(mon_exp[63:60]));
                compare_pkt("monbus_data", monbus_data, mon_exp);
            end
        end
    end

    // Run limit
    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with %0d packets still expected",
                 cycle_count, pending_count());
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        seed = 32'h7a65;
        for (int i = 0; i < 4; i++) begin
            seeds[i] = $random(seed);
        end
        rst = 1'b1;
        cfg_error_enable = 1'b0;
        cfg_compl_enable = 1'b0;
        for (int m = 0; m < 2; m++) begin
            {arid[m], araddr[m], arvalid[m], arready[m]} = '0;
            {rid[m], rresp[m], rlast[m], rvalid[m], rready[m]} = '0;
            {awid[m], awaddr[m], awvalid[m], awready[m]} = '0;
            {bid[m], bresp[m], bvalid[m], bready[m]} = '0;
        end
        repeat (16) @(posedge aclk);
        #1;
        rst = 1'b0;
        arready = '{1'b1, 1'b1};
        awready = '{1'b1, 1'b1};

        // Nothing may leave before the first completion
        repeat (8) begin
            step_cycle();
            if (monbus_valid !== 1'b0) begin
                other_errors++;
                $display("monbus_valid is not low after reset at %0t", $time);
            end
        end

        for (int ph = 0; ph < NUM_PHASES; ph++) begin
            if (ph < 3) begin
                cfg_compl_enable = (ph != 1);
                cfg_error_enable = (ph != 2);
            end else begin
                cfg_compl_enable = 1'($random(seed));
                cfg_error_enable = 1'($random(seed));
            end
            fork
                run_read_path(0);
                run_write_path(0);
                run_read_path(1);
                run_write_path(1);
            join
            step_cycle();
        end

        while (pending_count() != 0) begin
            @(posedge aclk);
        end
        repeat (8) @(posedge aclk);

        $display("Value errors: %0d, other errors: %0d, assertion failures: %0d",
                 value_errors, other_errors, assert_failures());
        if (value_errors + other_errors + assert_failures() == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+logic
logic/axi_fields_pkg.sv
logic/monbus_pkg.sv
logic/monbus_pkt_fifo.sv
logic/axi_rd_txn_mon.sv
logic/axi_wr_txn_mon.sv
logic/monbus_rr_arbiter.sv
logic/axi_monitor_top.sv
sim/axi_monitor_props.sv
sim/axi_monitor_tb.sv
